//--- verilog/gb_cart_pkg.sv
// gb_cart_pkg
// shared types and constants for the cartridge mapper
// mapper kinds, the decoded header, the CPU cart bus and the
// mapper register state, plus the header and address-region constants
package gb_cart_pkg;

	// ------------------------------
	// widths and keys
	// ------------------------------
	localparam int dl_aw  = 25;       // download byte address width
	localparam int rom_aw = 22;       // ROM word address width, 8MB of 16-bit words

	localparam logic [3:0] ram_en_key = 4'hA;   // low nibble that opens cart RAM

	// header byte addresses, both seen as the word holding the byte
	localparam logic [dl_aw-1:0] hdr_type_addr = 25'h000146;   // cartridge type in upper byte
	localparam logic [dl_aw-1:0] hdr_size_addr = 25'h000148;   // {ram code, rom code}

	// CPU regions, decoded from addr[15:13]
	localparam logic [2:0] rgn_ram_enable = 3'd0;   // 0000-1FFF
	localparam logic [2:0] rgn_rom_bank   = 3'd1;   // 2000-3FFF
	localparam logic [2:0] rgn_ram_bank   = 3'd2;   // 4000-5FFF
	localparam logic [2:0] rgn_mode       = 3'd3;   // 6000-7FFF
	localparam logic [2:0] rgn_cram       = 3'd5;   // A000-BFFF, cartridge RAM

	// ------------------------------
	// types
	// ------------------------------
	typedef enum logic [2:0] {
		kind_none = 3'd0,   // 32k flat ROM
		kind_mbc1 = 3'd1,
		kind_mbc2 = 3'd2,
		kind_mbc3 = 3'd3,
		kind_mbc5 = 3'd4
	} mbc_kind_e;

	// decoded header, 16 bits
	typedef struct packed {
		mbc_kind_e  kind;
		logic [8:0] rom_mask;   // bank bits that exist in the image
		logic [3:0] ram_mask;   // ram bank bits that exist
	} cart_hdr_t;

	// CPU side of the cartridge slot, 26 bits
	typedef struct packed {
		logic [15:0] addr;
		logic        rd;
		logic        wr;
		logic [7:0]  di;   // data from the CPU
	} cpu_bus_t;

	// mapper registers, 16 bits
	typedef struct packed {
		logic [8:0] rom_bank;
		logic [3:0] ram_bank;
		logic       mbc1_mode;    // 0 = 16/8 mode, ram bank drives upper rom bits
		logic       rtc_mode;     // mbc3 rtc selected instead of ram
		logic       ram_enable;
	} mbc_state_t;

endpackage

//--- verilog/cart_header_capture.sv
// cart_header_capture
// snoops the ROM download for the cartridge header and keeps
// the decoded mapper kind, ROM bank mask and RAM bank mask
module cart_header_capture (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         dl_cart,   // cart image downloading
	input  logic                         dl_wr,
	input  logic [gb_cart_pkg::dl_aw-1:0] dl_addr,
	input  logic [15:0]                  dl_data,
	output gb_cart_pkg::cart_hdr_t       hdr
);

	gb_cart_pkg::mbc_kind_e kind_nxt;
	logic [8:0] rom_mask_nxt;
	logic [3:0] ram_mask_nxt;

	// decode straight off the download word
	always_comb begin
		if (dl_data[15:8] inside {[8'd1:8'd3]})         kind_nxt = gb_cart_pkg::kind_mbc1;
		else if (dl_data[15:8] inside {[8'd5:8'd6]})    kind_nxt = gb_cart_pkg::kind_mbc2;
		else if (dl_data[15:8] inside {[8'd15:8'd19]})  kind_nxt = gb_cart_pkg::kind_mbc3;
		else if (dl_data[15:8] inside {[8'd25:8'd30]})  kind_nxt = gb_cart_pkg::kind_mbc5;
		else                                            kind_nxt = gb_cart_pkg::kind_none;

		// rom code n -> 2^(n+1) banks, n+1 mask bits
		if (dl_data[7:0] >= 8'd1 && dl_data[7:0] <= 8'd8)
			rom_mask_nxt = 9'h1ff >> (8'd8 - dl_data[7:0]);
		else
			rom_mask_nxt = 9'h07f;   // odd 72/80/96 bank sizes land here too

		if (dl_data[15:8] == 8'd3)      ram_mask_nxt = 4'b0011;   // 32k, 4 banks
		else if (dl_data[15:8] >= 8'd4) ram_mask_nxt = 4'b1111;   // 128k, 16 banks
		else                            ram_mask_nxt = 4'b0000;   // none, 2k or 8k
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hdr.kind     <= gb_cart_pkg::kind_none;
			hdr.rom_mask <= '0;
			hdr.ram_mask <= '0;
		end else if (dl_cart && dl_wr) begin
			if (dl_addr == gb_cart_pkg::hdr_type_addr)
				hdr.kind <= kind_nxt;
			if (dl_addr == gb_cart_pkg::hdr_size_addr) begin
				hdr.rom_mask <= rom_mask_nxt;   // low byte
				hdr.ram_mask <= ram_mask_nxt;   // high byte
			end
		end
	end

endmodule

//--- verilog/mbc_regs.sv
// mbc_regs
// mapper control registers, loaded by CPU writes into the
// 0000-7FFF ROM window; behaviour depends on the mapper kind
module mbc_regs (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cpu_ce,
	input  gb_cart_pkg::cpu_bus_t  cpu,
	input  gb_cart_pkg::mbc_kind_e kind,
	output gb_cart_pkg::mbc_state_t mstate
);

	logic wr_en;
	logic [2:0] rgn;

	assign wr_en = cpu_ce & cpu.wr;   // one write per cpu strobe
	assign rgn   = cpu.addr[15:13];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mstate.rom_bank   <= 9'd1;   // bank 1 sits at 4000 after power up
			mstate.ram_bank   <= 4'd0;
			mstate.mbc1_mode  <= 1'b0;
			mstate.rtc_mode   <= 1'b0;
			mstate.ram_enable <= 1'b0;
		end else if (wr_en) begin
			case (rgn)
				// ------------------------------
				gb_cart_pkg::rgn_ram_enable: begin
					// anything but the key closes it again
					mstate.ram_enable <= (cpu.di[3:0] == gb_cart_pkg::ram_en_key);
				end

				// ------------------------------
				gb_cart_pkg::rgn_rom_bank: begin
					if (kind == gb_cart_pkg::kind_mbc5) begin
						if (cpu.addr[12])
							mstate.rom_bank[8] <= cpu.di[0];        // 3000-3FFF high bit
						else
							mstate.rom_bank[7:0] <= cpu.di;         // 2000-2FFF low byte
					end else if (cpu.di[6:0] == 7'd0) begin
						mstate.rom_bank <= 9'd1;   // bank 0 cannot be picked here
					end else begin
						mstate.rom_bank <= {2'b00, cpu.di[6:0]};
					end
				end

				// ------------------------------
				gb_cart_pkg::rgn_ram_bank: begin
					if (kind == gb_cart_pkg::kind_mbc3) begin
						if (cpu.di[3]) begin
							mstate.rtc_mode <= 1'b1;   // 08-0C select rtc registers
						end else begin
							mstate.rtc_mode <= 1'b0;
							mstate.ram_bank <= {2'b00, cpu.di[1:0]};
						end
					end else if (kind == gb_cart_pkg::kind_mbc5) begin
						mstate.ram_bank <= cpu.di[3:0];   // 16 banks
					end else begin
						mstate.ram_bank <= {2'b00, cpu.di[1:0]};   // mbc1 also upper rom bits
					end
				end

				// ------------------------------
				gb_cart_pkg::rgn_mode: begin
					if (kind == gb_cart_pkg::kind_mbc1)
						mstate.mbc1_mode <= cpu.di[0];
				end

				default: ;   // cart ram and upper regions hold no registers
			endcase
		end
	end

endmodule

//--- verilog/mbc_addr_map.sv
// mbc_addr_map
// combinational address translation: CPU address plus mapper
// state gives the external ROM word address and the cart RAM address
// ROM word layout is {bank field[9:0], cpu_addr[12:1]}
module mbc_addr_map #(
	parameter int CRAM_AW = 17
) (
	input  logic [15:0]                    cpu_addr,
	input  gb_cart_pkg::cart_hdr_t         hdr,
	input  gb_cart_pkg::mbc_state_t        mstate,
	output logic [gb_cart_pkg::rom_aw-1:0] rom_addr,
	output logic [CRAM_AW-1:0]             cram_addr
);

	logic [6:0]  mbc1_bank;    // mbc1 bank incl. ram bank bits
	logic [8:0]  rom_bank_m;   // masked bank for the 4000-7FFF window
	logic [9:0]  bank_field;   // 8k unit, bit 0 is cpu_addr[13]
	logic [3:0]  ram_bank_m;
	logic [16:0] cram_full;    // 16 banks of 8k

	// in mode 0 the ram bank register supplies rom bits 6:5
	assign mbc1_bank = {mstate.mbc1_mode ? 2'b00 : mstate.ram_bank[1:0],
		mstate.rom_bank[4:0]} & hdr.rom_mask[6:0];

	// ------------------------------
	// ROM banking
	// ------------------------------
	always_comb begin
		case (hdr.kind)
			gb_cart_pkg::kind_mbc1: rom_bank_m = {2'b00, mbc1_bank};
			gb_cart_pkg::kind_mbc2: rom_bank_m = {5'd0, mstate.rom_bank[3:0] & hdr.rom_mask[3:0]};
			gb_cart_pkg::kind_mbc3: rom_bank_m = {2'b00, mstate.rom_bank[6:0] & hdr.rom_mask[6:0]};
			gb_cart_pkg::kind_mbc5: rom_bank_m = mstate.rom_bank & hdr.rom_mask;   // up to 512
			default:                rom_bank_m = 9'd0;
		endcase

		if (hdr.kind == gb_cart_pkg::kind_none)
			bank_field = {8'd0, cpu_addr[14:13]};          // flat 32k
		else if (cpu_addr[15:14] == 2'b01)
			bank_field = {rom_bank_m, cpu_addr[13]};       // switchable window
		else
			bank_field = {9'd0, cpu_addr[13]};             // fixed bank 0
	end

	assign rom_addr = {bank_field, cpu_addr[12:1]};

	// ------------------------------
	// RAM banking
	// ------------------------------
	always_comb begin
		case (hdr.kind)
			gb_cart_pkg::kind_mbc1: begin
				// mode 0 keeps ram unbanked
				ram_bank_m = mstate.mbc1_mode ?
					{2'b00, mstate.ram_bank[1:0] & hdr.ram_mask[1:0]} : 4'd0;
			end
			gb_cart_pkg::kind_mbc3: ram_bank_m = {2'b00, mstate.ram_bank[1:0] & hdr.ram_mask[1:0]};
			gb_cart_pkg::kind_mbc5: ram_bank_m = mstate.ram_bank & hdr.ram_mask;
			default:                ram_bank_m = 4'd0;   // mbc2 and none have one bank
		endcase
	end

	assign cram_full = {ram_bank_m, cpu_addr[12:0]};
	assign cram_addr = cram_full[CRAM_AW-1:0];   // narrower ram mirrors upper banks

endmodule

//--- verilog/cart_ram.sv
// cart_ram
// banked cartridge RAM, byte wide, written on the CPU strobe
// read is registered every clk_sys, then masked for
// disabled RAM, MBC2 nibble RAM and MBC3 rtc mode
module cart_ram #(
	parameter int CRAM_AW = 17
) (
	input  logic                    clk_sys,
	input  logic                    cpu_ce,
	input  logic                    we,        // cpu write into A000-BFFF
	input  logic [CRAM_AW-1:0]      addr,
	input  logic [7:0]              di,
	input  gb_cart_pkg::mbc_kind_e  kind,
	input  gb_cart_pkg::mbc_state_t mstate,
	output logic [7:0]              cram_do
);

	logic [7:0] mem [0:(1 << CRAM_AW) - 1];
	logic [7:0] q;

	always_ff @(posedge clk_sys) begin
		if (cpu_ce && we)
			mem[addr] <= di;
		q <= mem[addr];   // data one cycle after the address
	end

	// output masking, order matters
	always_comb begin
		if (!mstate.ram_enable)
			cram_do = 8'hff;                  // closed ram floats high
		else if (kind == gb_cart_pkg::kind_mbc2)
			cram_do = {4'hf, q[3:0]};         // 512x4 ram, top nibble open
		else if (mstate.rtc_mode)
			cram_do = 8'h00;                  // no rtc behind it
		else
			cram_do = q;
	end

endmodule

//--- verilog/gb_cart_mapper.sv
// gb_cart_mapper
// cartridge side of the console: header capture, mapper
// registers, ROM/RAM address mapping, cart RAM and the
// read-data mux back to the CPU
module gb_cart_mapper #(
	parameter int CRAM_AW = 17   // 128k of cart ram
) (
	input  logic                          clk_sys,
	input  logic                          reset,
	// download port
	input  logic                          dl_cart,
	input  logic                          dl_wr,
	input  logic [gb_cart_pkg::dl_aw-1:0]  dl_addr,
	input  logic [15:0]                   dl_data,
	// cpu port
	input  logic                          cpu_ce,
	input  gb_cart_pkg::cpu_bus_t         cpu,
	output logic [7:0]                    cpu_do,
	// external rom, word wide
	output logic [gb_cart_pkg::rom_aw-1:0] rom_addr,
	input  logic [15:0]                   rom_q
);

	gb_cart_pkg::cart_hdr_t  hdr;
	gb_cart_pkg::mbc_state_t mstate;
	logic [CRAM_AW-1:0]      cram_addr;
	logic [7:0]              cram_do;
	logic                    is_cram;
	logic                    cram_rd;
	logic                    cram_we;

	// ------------------------------
	// blocks
	// ------------------------------
	cart_header_capture u_hdr (
		.clk_sys (clk_sys),
		.reset   (reset),
		.dl_cart (dl_cart),
		.dl_wr   (dl_wr),
		.dl_addr (dl_addr),
		.dl_data (dl_data),
		.hdr     (hdr)
	);

	mbc_regs u_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cpu_ce  (cpu_ce),
		.cpu     (cpu),
		.kind    (hdr.kind),
		.mstate  (mstate)
	);

	mbc_addr_map #(.CRAM_AW(CRAM_AW)) u_map (
		.cpu_addr  (cpu.addr),
		.hdr       (hdr),
		.mstate    (mstate),
		.rom_addr  (rom_addr),
		.cram_addr (cram_addr)
	);

	cart_ram #(.CRAM_AW(CRAM_AW)) u_cram (
		.clk_sys (clk_sys),
		.cpu_ce  (cpu_ce),
		.we      (cram_we),
		.addr    (cram_addr),
		.di      (cpu.di),
		.kind    (hdr.kind),
		.mstate  (mstate),
		.cram_do (cram_do)
	);

	// ------------------------------
	// read steering
	// ------------------------------
	assign is_cram = (cpu.addr[15:13] == gb_cart_pkg::rgn_cram);
	assign cram_rd = cpu.rd & is_cram;
	assign cram_we = cpu.wr & is_cram;

	// rom word holds two bytes, odd address takes the high one
	assign cpu_do = cram_rd    ? cram_do     :
	                cpu.addr[0] ? rom_q[15:8] : rom_q[7:0];

endmodule

//--- verification/gb_cart_mapper_props.sv
// gb_cart_mapper_props
// concurrent checks bound into the mapper top level
// closed cart RAM reads FF, fixed ROM window is always bank 0
module gb_cart_mapper_props (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  gb_cart_pkg::cpu_bus_t          cpu,
	input  gb_cart_pkg::mbc_state_t        mstate,
	input  logic                           cram_rd,
	input  logic [7:0]                     cpu_do,
	input  logic [gb_cart_pkg::rom_aw-1:0] rom_addr
);
	timeunit 1ns;
	timeprecision 100ps;

	int ff_fail = 0;      // closed ram read gave something else
	int bank0_fail = 0;   // 0000-3FFF left bank 0

	// ------------------------------
	// cart ram closed
	// ------------------------------
	// a read held for a cycle has its registered data on cpu_do
	closed_ram_reads_ff: assert property (@(posedge clk_sys) disable iff (reset)
		($past(cram_rd) && cram_rd && !mstate.ram_enable) |-> (cpu_do == 8'hff))
	else begin
		$error("cart RAM read with RAM disabled returned %h", cpu_do);
		ff_fail++;
	end

	// ------------------------------
	// fixed rom window
	// ------------------------------
	// bank bits sit above the 8k offset, rom_addr[21:13]
	low_window_bank0: assert property (@(posedge clk_sys) disable iff (reset)
		(cpu.addr[15:14] == 2'b00) |-> (rom_addr[21:13] == 9'd0))
	else begin
		$error("address %h below 4000 mapped to rom_addr %h", cpu.addr, rom_addr);
		bank0_fail++;
	end

endmodule

bind gb_cart_mapper gb_cart_mapper_props u_props (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.cpu      (cpu),
	.mstate   (mstate),
	.cram_rd  (cram_rd),
	.cpu_do   (cpu_do),
	.rom_addr (rom_addr)
);

//--- verification/tb_gb_cart_mapper.sv
// tb_gb_cart_mapper
// testbench for the cartridge mapper: downloads a header, drives
// CPU reads and writes on the cpu_ce strobe, models the ROM and
// checks ROM mapping, register behaviour and cart RAM per mapper kind
module tb_gb_cart_mapper;
	timeunit 1ns;
	timeprecision 100ps;

	logic clk_sys = 1'b0;
	logic reset, dl_cart, dl_wr, cpu_ce;
	logic [gb_cart_pkg::dl_aw-1:0] dl_addr;
	logic [15:0] dl_data, rom_q;
	logic [gb_cart_pkg::rom_aw-1:0] rom_addr;
	logic [7:0] cpu_do;
	gb_cart_pkg::cpu_bus_t cpu;
	logic [1:0] ce_cnt = 2'd0;
	int seed = 12;
	int errors = 0;
	int checks = 0;
	logic [31:0] rnd;
	logic [7:0] bank_lo;
	logic [15:0] ram_a [4];
	logic [7:0] ram_d [4];

	gb_cart_mapper UUT (.*);

	always #2 clk_sys = ~clk_sys;   // 4 ns period
	assign rom_q = rom_addr[15:0] ^ 16'h5a3c;   // rom model, word scrambled by a fixed key

	always @(posedge clk_sys) begin
		ce_cnt <= ce_cnt + 2'd1;
		cpu_ce <= (ce_cnt == 2'd3);   // one strobe in 4
	end

	// ------------------------------
	// stimulus helpers
	// ------------------------------
	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic do_reset();
		@(posedge clk_sys);
		reset <= 1'b1;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
	endtask

	task automatic dl_word(input logic [gb_cart_pkg::dl_aw-1:0] a, input logic [15:0] d);
		@(posedge clk_sys);
		dl_cart <= 1'b1;
		dl_wr   <= 1'b1;
		dl_addr <= a;
		dl_data <= d;
		@(posedge clk_sys);
		dl_wr   <= 1'b0;   // header latched at this edge
	endtask

	task automatic load_cart(input logic [7:0] ctype, input logic [7:0] rom_code,
		input logic [7:0] ram_code);
		dl_word(gb_cart_pkg::hdr_type_addr, {ctype, 8'h00});
		dl_word(gb_cart_pkg::hdr_size_addr, {ram_code, rom_code});
		@(posedge clk_sys);
		dl_cart <= 1'b0;
	endtask

	// hold a write until the dut sees it on a cpu_ce edge
	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		int n;
		n = 0;
		@(posedge clk_sys);
		cpu.addr <= a;
		cpu.rd   <= 1'b0;
		cpu.wr   <= 1'b1;
		cpu.di   <= d;
		do begin
			@(posedge clk_sys);
			n++;
		end while (!cpu_ce && n < 16);
		if (!cpu_ce) begin
			$display("Timeout: no cpu_ce strobe within 16 cycles for a write to %h", a);
			$display("Test FAILED");
			$finish;
		end else begin
			cpu.wr <= 1'b0;
		end
	endtask

	// rom data is combinational, ram data lands one cycle later
	task automatic cpu_read(input logic [15:0] a);
		@(posedge clk_sys);
		cpu.addr <= a;
		cpu.rd   <= 1'b1;
		cpu.wr   <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);   // sample mid cycle
	endtask

	// expected word address is {bank, a[13:1]}, byte picked by a[0]
	task automatic check_rom(input logic [15:0] a, input logic [8:0] bank);
		logic [21:0] exp_addr;
		logic [15:0] w;
		exp_addr = {bank, a[13:1]};
		w = exp_addr[15:0] ^ 16'h5a3c;
		cpu_read(a);
		check_val("rom_addr", 32'(rom_addr), 32'(exp_addr));
		check_val("cpu_do", 32'(cpu_do), 32'(a[0] ? w[15:8] : w[7:0]));
	endtask

	task automatic check_ram(input logic [15:0] a, input logic [7:0] exp);
		cpu_read(a);
		check_val("cpu_do", 32'(cpu_do), 32'(exp));
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		reset = 1'b1;
		dl_cart = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		cpu_ce = 1'b0;
		cpu = '0;
		do_reset();

		// flat rom, no mapper
		load_cart(8'd0, 8'd0, 8'd0);
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			check_rom({1'b0, rnd[14:0]}, {8'd0, rnd[14]});
		end

		// mbc1 straight out of reset: bank 1 at 4000, ram closed
		do_reset();
		load_cart(8'd1, 8'd4, 8'd0);   // 32 banks
		check_rom(16'h4000, 9'd1);
		check_ram(16'ha000, 8'hff);
		check_rom(16'h1235, 9'd0);
		cpu_write(16'h2000, 8'h00);   // 0 turns into 1
		check_rom(16'h5001, 9'd1);
		cpu_write(16'h2000, 8'h25);
		check_rom(16'h4002, 9'h05);
		cpu_write(16'h4000, 8'h02);   // mode 0, ram bank feeds bits 6:5
		check_rom(16'h4002, 9'h05);   // still masked by the 32 bank image
		load_cart(8'd1, 8'd6, 8'd0);  // 128 banks
		check_rom(16'h7ffe, 9'h45);

		// every register moved off its reset value, then reset again
		cpu_write(16'h0000, 8'h0a);   // ram open
		cpu_write(16'h6000, 8'h01);   // mode 1
		do_reset();
		load_cart(8'd1, 8'd6, 8'd0);
		check_rom(16'h4000, 9'd1);
		check_ram(16'ha000, 8'hff);

		// mbc5, 9 bit bank
		do_reset();
		load_cart(8'd25, 8'd8, 8'd0);
		rnd = $random(seed);
		bank_lo = rnd[7:0];
		cpu_write(16'h2000, bank_lo);
		cpu_write(16'h3000, 8'h01);
		check_rom({2'b01, rnd[21:8]}, {1'b1, bank_lo});

		// mbc5 cart ram, 16 banks
		do_reset();
		load_cart(8'd25, 8'd8, 8'd4);
		check_ram(16'ha000, 8'hff);   // no key yet
		cpu_write(16'h0000, 8'h0a);
		cpu_write(16'h4000, 8'h03);
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			ram_a[i] = {3'b101, i[1:0], 3'b000, rnd[7:0]};
			ram_d[i] = rnd[15:8];
			cpu_write(ram_a[i], ram_d[i]);
		end
		cpu_write(16'h4000, 8'h00);
		for (int i = 0; i < 4; i++)
			cpu_write(ram_a[i], ~ram_d[i]);   // same offsets in bank 0
		for (int i = 0; i < 4; i++)
			check_ram(ram_a[i], ~ram_d[i]);
		cpu_write(16'h4000, 8'h03);
		for (int i = 0; i < 4; i++)
			check_ram(ram_a[i], ram_d[i]);

		// mbc2 nibble ram
		do_reset();
		load_cart(8'd5, 8'd1, 8'd0);
		cpu_write(16'h0000, 8'h0a);
		cpu_write(16'ha010, 8'h3c);
		check_ram(16'ha010, 8'hfc);

		// mbc3, rtc select hides the ram
		do_reset();
		load_cart(8'd15, 8'd1, 8'd3);
		cpu_write(16'h0000, 8'h0a);
		cpu_write(16'ha020, 8'h77);
		check_ram(16'ha020, 8'h77);
		cpu_write(16'h4000, 8'h08);
		check_ram(16'ha020, 8'h00);

		@(posedge clk_sys);
		cpu.rd <= 1'b0;
		repeat (2) @(posedge clk_sys);

		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			UUT.u_props.ff_fail + UUT.u_props.bank0_fail);
		if (errors == 0 && UUT.u_props.ff_fail == 0 && UUT.u_props.bank0_fail == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
verilog/gb_cart_pkg.sv
verilog/cart_header_capture.sv
verilog/mbc_regs.sv
verilog/mbc_addr_map.sv
verilog/cart_ram.sv
verilog/gb_cart_mapper.sv
verification/gb_cart_mapper_props.sv
verification/tb_gb_cart_mapper.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cartridge mapper testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f flist.f \
	--top-module tb_gb_cart_mapper \
	--Mdir obj_dir -o tb_sim

# the simulator may stop early on an assertion, so keep going to the log check
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test OK" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi
